//--- src/mmu_cfg.svh
`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

//////////////////////////////////////////////////
// tlb geometry
//////////////////////////////////////////////////
`define TLB_ENTRIES 16
`define TLB_IDX_W   4
`define ASID_W      8

//////////////////////////////////////////////////
// segment map
//////////////////////////////////////////////////
// kseg0 and kseg1 are unmapped, kseg2 starts the mapped upper half
`define KSEG0_BASE  32'h8000_0000
`define KSEG1_BASE  32'hA000_0000
`define KSEG2_BASE  32'hC000_0000

`endif

//--- src/mmu_pkg.sv
`include "mmu_cfg.svh"

package mmu_pkg;

    // tlb instructions
    typedef enum logic [2:0] {
        TLB_NOP       = 3'd0,
        TLB_READ      = 3'd1,
        TLB_WRITE_IDX = 3'd2,
        TLB_WRITE_RND = 3'd3,
        TLB_PROBE     = 3'd4
    } tlb_op_e;

    typedef enum logic [1:0] {
        CTL_IDLE = 2'd0,
        CTL_EXEC = 2'd1,
        CTL_DONE = 2'd2
    } ctl_state_e;

    // cp0 register select, tlb related only
    typedef enum logic [2:0] {
        SEL_INDEX    = 3'd0,
        SEL_ENTRYHI  = 3'd1,
        SEL_ENTRYLO0 = 3'd2,
        SEL_ENTRYLO1 = 3'd3,
        SEL_WIRED    = 3'd4,
        SEL_RANDOM   = 3'd5
    } cp0_sel_e;

    // one dual-page entry, even page then odd page
    typedef struct packed {
        logic [18:0]        vpn2;
        logic [`ASID_W-1:0] asid;
        logic               g;
        logic [19:0]        pfn0;
        logic [2:0]         c0;
        logic               d0;
        logic               v0;
        logic [19:0]        pfn1;
        logic [2:0]         c1;
        logic               d1;
        logic               v1;
    } tlb_entry_t;

endpackage

//--- src/tlb_if.sv
`include "mmu_cfg.svh"

// one associative search port, results valid in the same cycle
interface tlb_search_if;
    logic [18:0]           vpn2;
    logic                  odd_page;
    logic [`ASID_W-1:0]    asid;
    logic                  found;
    logic [`TLB_IDX_W-1:0] index;
    logic [19:0]           pfn;
    logic [2:0]            c;
    logic                  d;
    logic                  v;

    modport requester (output vpn2, odd_page, asid, input found, index, pfn, c, d, v);
    modport responder (input vpn2, odd_page, asid, output found, index, pfn, c, d, v);
    // probe result only
    modport observer (input found, index);
endinterface

// write port and read port of the entry array
interface tlb_rw_if import mmu_pkg::*;;
    logic                  we;
    logic [`TLB_IDX_W-1:0] w_index;
    tlb_entry_t            w_entry;
    logic [`TLB_IDX_W-1:0] r_index;
    tlb_entry_t            r_entry;

    modport master (output we, w_index, w_entry, r_index, input r_entry);
    modport slave (input we, w_index, w_entry, r_index, output r_entry);
endinterface

//--- src/tlb.sv
`include "mmu_cfg.svh"

module tlb import mmu_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    tlb_search_if.responder    s0,
    tlb_search_if.responder    s1,
    tlb_rw_if.slave            rw
);

    tlb_entry_t               entries [`TLB_ENTRIES];

    logic [`TLB_ENTRIES-1:0]  s0_hit;
    logic [`TLB_ENTRIES-1:0]  s1_hit;
    logic [`TLB_IDX_W-1:0]    s0_idx;
    logic [`TLB_IDX_W-1:0]    s1_idx;
    logic [`TLB_ENTRIES-1:0]  live;

    //////////////////////////////////////////////////
    // match helpers
    //////////////////////////////////////////////////

    // vpn2 compare, asid ignored for global entries
    function automatic logic [`TLB_ENTRIES-1:0] match_mask(
        input logic [18:0]        vpn2,
        input logic [`ASID_W-1:0] asid
    );
        logic [`TLB_ENTRIES-1:0] hit;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            hit[i] = (entries[i].vpn2 == vpn2) && (entries[i].g || entries[i].asid == asid);
        end
        return hit;
    endfunction

    // lowest matching entry wins
    function automatic logic [`TLB_IDX_W-1:0] first_hit(
        input logic [`TLB_ENTRIES-1:0] hit
    );
        logic [`TLB_IDX_W-1:0] idx;
        idx = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                idx = `TLB_IDX_W'(i);
            end
        end
        return idx;
    endfunction

    // {pfn, c, d, v} of the even or odd page
    function automatic logic [24:0] pick_page(
        input tlb_entry_t e,
        input logic       odd
    );
        if (odd) begin
            return {e.pfn1, e.c1, e.d1, e.v1};
        end
        return {e.pfn0, e.c0, e.d0, e.v0};
    endfunction

    //////////////////////////////////////////////////
    // search ports
    //////////////////////////////////////////////////
    always_comb begin
        s0_hit   = match_mask(s0.vpn2, s0.asid);
        s0_idx   = first_hit(s0_hit);
        s0.found = |s0_hit;
        s0.index = s0_idx;
        {s0.pfn, s0.c, s0.d, s0.v} = pick_page(entries[s0_idx], s0.odd_page);
    end

    always_comb begin
        s1_hit   = match_mask(s1.vpn2, s1.asid);
        s1_idx   = first_hit(s1_hit);
        s1.found = |s1_hit;
        s1.index = s1_idx;
        {s1.pfn, s1.c, s1.d, s1.v} = pick_page(entries[s1_idx], s1.odd_page);
    end

    // read port
    assign rw.r_entry = entries[rw.r_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (rw.we) begin
            entries[rw.w_index] <= rw.w_entry;
        end
    end

    // only entries holding a valid page count as duplicates
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            live[i] = entries[i].v0 | entries[i].v1;
        end
    end

    a_single_match: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(s0_hit & live) && $onehot0(s1_hit & live)
    ) else $error("tlb: more than one entry matches a search");

endmodule

//--- src/tlb_random.sv
`include "mmu_cfg.svh"

module tlb_random import mmu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`TLB_IDX_W-1:0] wired,
    input  logic                  wired_wr,
    output logic [`TLB_IDX_W-1:0] random
);

    localparam logic [`TLB_IDX_W-1:0] TOP = `TLB_IDX_W'(`TLB_ENTRIES - 1);

    // counts down to wired, then wraps to the top entry
    always_ff @(posedge clk) begin
        if (reset) begin
            random <= TOP;
        end else if (wired_wr) begin
            random <= TOP;
        end else if (random <= wired) begin
            random <= TOP;
        end else begin
            random <= random - 1'b1;
        end
    end

    // victim never lands in the wired region
    a_above_wired: assert property (
        @(posedge clk) disable iff (reset)
        (random >= wired) || $past(wired_wr)
    ) else $error("tlb_random: random %0d below wired %0d", random, wired);

endmodule

//--- src/tlb_ctrl.sv
`include "mmu_cfg.svh"

module tlb_ctrl import mmu_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               op_start,
    input  tlb_op_e            op,
    input  logic               cp0_wr_en,
    input  cp0_sel_e           cp0_sel,
    input  logic [31:0]        cp0_wr_data,
    output logic [31:0]        cp0_rd_data,
    output logic               busy,
    output logic               op_done,
    output logic               probe_active,
    output logic [18:0]        entryhi_vpn2,
    output logic [`ASID_W-1:0] cur_asid,
    tlb_rw_if.master           rw,
    tlb_search_if.observer     probe
);

    ctl_state_e            state;
    tlb_op_e               op_q;
    logic                  in_exec;
    logic                  cp0_we;
    logic                  wired_wr;

    // cp0 registers
    logic                  index_p;
    logic [`TLB_IDX_W-1:0] index_val;
    logic [18:0]           ehi_vpn2;
    logic [`ASID_W-1:0]    ehi_asid;
    logic [25:0]           entrylo0;
    logic [25:0]           entrylo1;
    logic [`TLB_IDX_W-1:0] wired;
    logic [`TLB_IDX_W-1:0] random;

    assign in_exec      = (state == CTL_EXEC);
    assign busy         = (state != CTL_IDLE);
    assign op_done      = (state == CTL_DONE);
    assign probe_active = in_exec && (op_q == TLB_PROBE);
    assign cp0_we       = cp0_wr_en && !busy;
    assign wired_wr     = cp0_we && (cp0_sel == SEL_WIRED);
    assign entryhi_vpn2 = ehi_vpn2;
    assign cur_asid     = ehi_asid;

    tlb_random u_tlb_random (
        .clk      (clk),
        .reset    (reset),
        .wired    (wired),
        .wired_wr (wired_wr),
        .random   (random)
    );

    //////////////////////////////////////////////////
    // operation FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= CTL_IDLE;
            op_q  <= TLB_NOP;
        end else begin
            case (state)
                CTL_IDLE: begin
                    if (op_start) begin
                        state <= CTL_EXEC;
                        op_q  <= op;
                    end
                end
                CTL_EXEC: state <= CTL_DONE;
                default:  state <= CTL_IDLE;
            endcase
        end
    end

    // array write, g is the AND of both lo g bits
    assign rw.we      = in_exec && (op_q == TLB_WRITE_IDX || op_q == TLB_WRITE_RND);
    assign rw.w_index = (op_q == TLB_WRITE_RND) ? random : index_val;
    assign rw.r_index = index_val;

    always_comb begin
        rw.w_entry.vpn2 = ehi_vpn2;
        rw.w_entry.asid = ehi_asid;
        rw.w_entry.g    = entrylo0[0] & entrylo1[0];
        {rw.w_entry.pfn0, rw.w_entry.c0, rw.w_entry.d0, rw.w_entry.v0} = entrylo0[25:1];
        {rw.w_entry.pfn1, rw.w_entry.c1, rw.w_entry.d1, rw.w_entry.v1} = entrylo1[25:1];
    end

    //////////////////////////////////////////////////
    // cp0 register file
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            index_p   <= 1'b0;
            index_val <= '0;
            ehi_vpn2  <= '0;
            ehi_asid  <= '0;
            entrylo0  <= '0;
            entrylo1  <= '0;
            wired     <= '0;
        end else if (cp0_we) begin
            case (cp0_sel)
                SEL_INDEX: begin
                    index_p   <= cp0_wr_data[31];
                    index_val <= cp0_wr_data[`TLB_IDX_W-1:0];
                end
                SEL_ENTRYHI: begin
                    ehi_vpn2 <= cp0_wr_data[31:13];
                    ehi_asid <= cp0_wr_data[`ASID_W-1:0];
                end
                SEL_ENTRYLO0: entrylo0 <= cp0_wr_data[25:0];
                SEL_ENTRYLO1: entrylo1 <= cp0_wr_data[25:0];
                SEL_WIRED:    wired <= cp0_wr_data[`TLB_IDX_W-1:0];
                default: ;
            endcase
        end else if (in_exec) begin
            case (op_q)
                TLB_READ: begin
                    ehi_vpn2 <= rw.r_entry.vpn2;
                    ehi_asid <= rw.r_entry.asid;
                    entrylo0 <= {rw.r_entry.pfn0, rw.r_entry.c0, rw.r_entry.d0,
                                 rw.r_entry.v0, rw.r_entry.g};
                    entrylo1 <= {rw.r_entry.pfn1, rw.r_entry.c1, rw.r_entry.d1,
                                 rw.r_entry.v1, rw.r_entry.g};
                end
                TLB_PROBE: begin
                    // miss keeps the old index field
                    index_p <= !probe.found;
                    if (probe.found) begin
                        index_val <= probe.index;
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (cp0_sel)
            SEL_INDEX:    cp0_rd_data = {index_p, {(31 - `TLB_IDX_W){1'b0}}, index_val};
            SEL_ENTRYHI:  cp0_rd_data = {ehi_vpn2, {(13 - `ASID_W){1'b0}}, ehi_asid};
            SEL_ENTRYLO0: cp0_rd_data = {6'b0, entrylo0};
            SEL_ENTRYLO1: cp0_rd_data = {6'b0, entrylo1};
            SEL_WIRED:    cp0_rd_data = {{(32 - `TLB_IDX_W){1'b0}}, wired};
            SEL_RANDOM:   cp0_rd_data = {{(32 - `TLB_IDX_W){1'b0}}, random};
            default:      cp0_rd_data = '0;
        endcase
    end

    a_no_start_busy: assert property (
        @(posedge clk) disable iff (reset) op_start |-> !busy
    ) else $error("tlb_ctrl: op_start while busy");

endmodule

//--- src/mmu_translate.sv
`include "mmu_cfg.svh"

module mmu_translate import mmu_pkg::*; (
    input  logic [31:0]        iaddr,
    input  logic [31:0]        daddr,
    input  logic               d_write,
    input  logic               probe_active,
    input  logic [18:0]        entryhi_vpn2,
    input  logic [`ASID_W-1:0] cur_asid,
    tlb_search_if.requester    si,
    tlb_search_if.requester    sd,
    output logic [31:0]        i_paddr,
    output logic [31:0]        d_paddr,
    output logic               i_refill,
    output logic               i_invalid,
    output logic               d_refill,
    output logic               d_invalid,
    output logic               d_modify
);

    localparam logic [31:0] KSEG0 = `KSEG0_BASE;
    localparam logic [31:0] KSEG1 = `KSEG1_BASE;

    logic i_kseg0;
    logic i_kseg1;
    logic d_kseg0;
    logic d_kseg1;

    // unmapped segments decode on the top three bits
    assign i_kseg0 = (iaddr[31:29] == KSEG0[31:29]);
    assign i_kseg1 = (iaddr[31:29] == KSEG1[31:29]);
    assign d_kseg0 = (daddr[31:29] == KSEG0[31:29]);
    assign d_kseg1 = (daddr[31:29] == KSEG1[31:29]);

    //////////////////////////////////////////////////
    // search requests
    //////////////////////////////////////////////////
    assign si.vpn2     = iaddr[31:13];
    assign si.odd_page = iaddr[12];
    assign si.asid     = cur_asid;

    // tlbp borrows the data port for its exec cycle
    assign sd.vpn2     = probe_active ? entryhi_vpn2 : daddr[31:13];
    assign sd.odd_page = daddr[12];
    assign sd.asid     = cur_asid;

    //////////////////////////////////////////////////
    // fetch side
    //////////////////////////////////////////////////
    always_comb begin
        i_paddr   = {si.pfn, iaddr[11:0]};
        i_refill  = 1'b0;
        i_invalid = 1'b0;
        if (i_kseg0) begin
            i_paddr = iaddr - KSEG0;
        end else if (i_kseg1) begin
            i_paddr = iaddr - KSEG1;
        end else begin
            i_refill  = !si.found;
            i_invalid = si.found && !si.v;
        end
    end

    //////////////////////////////////////////////////
    // data side
    //////////////////////////////////////////////////
    always_comb begin
        d_paddr   = {sd.pfn, daddr[11:0]};
        d_refill  = 1'b0;
        d_invalid = 1'b0;
        d_modify  = 1'b0;
        if (d_kseg0) begin
            d_paddr = daddr - KSEG0;
        end else if (d_kseg1) begin
            d_paddr = daddr - KSEG1;
        end else begin
            d_refill  = !sd.found;
            d_invalid = sd.found && !sd.v;
            // store to a clean page
            d_modify  = sd.found && d_write && !sd.d;
        end
    end

endmodule

//--- src/mmu_top.sv
`include "mmu_cfg.svh"

module mmu_top import mmu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] iaddr,
    input  logic [31:0] daddr,
    input  logic        d_write,
    input  logic        op_start,
    input  tlb_op_e     op,
    output logic        busy,
    output logic        op_done,
    input  logic        cp0_wr_en,
    input  cp0_sel_e    cp0_sel,
    input  logic [31:0] cp0_wr_data,
    output logic [31:0] cp0_rd_data,
    output logic [31:0] i_paddr,
    output logic [31:0] d_paddr,
    output logic        i_refill,
    output logic        i_invalid,
    output logic        d_refill,
    output logic        d_invalid,
    output logic        d_modify
);

    logic               probe_active;
    logic [18:0]        entryhi_vpn2;
    logic [`ASID_W-1:0] cur_asid;

    // port 0 fetch, port 1 data and probe
    tlb_search_if search_i ();
    tlb_search_if search_d ();
    tlb_rw_if     rw_bus ();

    tlb u_tlb (
        .clk   (clk),
        .reset (reset),
        .s0    (search_i.responder),
        .s1    (search_d.responder),
        .rw    (rw_bus.slave)
    );

    tlb_ctrl u_tlb_ctrl (
        .clk          (clk),
        .reset        (reset),
        .op_start     (op_start),
        .op           (op),
        .cp0_wr_en    (cp0_wr_en),
        .cp0_sel      (cp0_sel),
        .cp0_wr_data  (cp0_wr_data),
        .cp0_rd_data  (cp0_rd_data),
        .busy         (busy),
        .op_done      (op_done),
        .probe_active (probe_active),
        .entryhi_vpn2 (entryhi_vpn2),
        .cur_asid     (cur_asid),
        .rw           (rw_bus.master),
        .probe        (search_d.observer)
    );

    mmu_translate u_mmu_translate (
        .iaddr        (iaddr),
        .daddr        (daddr),
        .d_write      (d_write),
        .probe_active (probe_active),
        .entryhi_vpn2 (entryhi_vpn2),
        .cur_asid     (cur_asid),
        .si           (search_i.requester),
        .sd           (search_d.requester),
        .i_paddr      (i_paddr),
        .d_paddr      (d_paddr),
        .i_refill     (i_refill),
        .i_invalid    (i_invalid),
        .d_refill     (d_refill),
        .d_invalid    (d_invalid),
        .d_modify     (d_modify)
    );

endmodule

//--- sim/tb_mmu_tasks.svh
//////////////////////////////////////////////////
// cp0 access and operation issue
//////////////////////////////////////////////////
task automatic cp0_write(input cp0_sel_e sel, input logic [31:0] data);
    @(posedge clk);
    cp0_wr_en   <= 1'b1;
    cp0_sel     <= sel;
    cp0_wr_data <= data;
    @(posedge clk);
    cp0_wr_en <= 1'b0;
endtask

task automatic cp0_read(input cp0_sel_e sel, output logic [31:0] data);
    @(posedge clk);
    cp0_sel <= sel;
    @(negedge clk);
    data = cp0_rd_data;
endtask

// returns in the op_done cycle, the global cycle counter guards the wait
task automatic issue_op(input tlb_op_e o);
    @(posedge clk);
    op_start <= 1'b1;
    op       <= o;
    @(posedge clk);
    op_start <= 1'b0;
    op       <= TLB_NOP;
    @(negedge clk);
    while (!op_done) begin
        @(negedge clk);
    end
endtask

task automatic set_entryhi(input logic [18:0] vpn2, input logic [7:0] asid);
    cp0_write(SEL_ENTRYHI, {vpn2, 5'b0, asid});
    cur_asid_m = asid;
endtask

//////////////////////////////////////////////////
// reference model of the entry array
//////////////////////////////////////////////////
function automatic logic [31:0] make_lo(input logic [19:0] pfn, input logic [2:0] c,
                                        input logic d, input logic v, input logic g);
    return {6'b0, pfn, c, d, v, g};
endfunction

function automatic void shadow_store(input int idx, input logic [18:0] vpn2,
                                     input logic [7:0] asid, input logic [31:0] lo0,
                                     input logic [31:0] lo1);
    shadow[idx].vpn2 = vpn2;
    shadow[idx].asid = asid;
    shadow[idx].g    = lo0[0] & lo1[0];
    {shadow[idx].pfn0, shadow[idx].c0, shadow[idx].d0, shadow[idx].v0} = lo0[25:1];
    {shadow[idx].pfn1, shadow[idx].c1, shadow[idx].d1, shadow[idx].v1} = lo1[25:1];
endfunction

task automatic tlbwi_entry(input int idx, input logic [18:0] vpn2, input logic [7:0] asid,
                           input logic [31:0] lo0, input logic [31:0] lo1);
    cp0_write(SEL_INDEX, 32'(idx));
    set_entryhi(vpn2, asid);
    cp0_write(SEL_ENTRYLO0, lo0);
    cp0_write(SEL_ENTRYLO1, lo1);
    issue_op(TLB_WRITE_IDX);
    shadow_store(idx, vpn2, asid, lo0, lo1);
endtask

// lowest matching index, -1 on a miss
function automatic int find_entry(input logic [18:0] vpn2, input logic [7:0] asid);
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
        if (shadow[i].vpn2 == vpn2 && (shadow[i].g || shadow[i].asid == asid)) begin
            return i;
        end
    end
    return -1;
endfunction

// flags are {refill, invalid, modify}
function automatic void model_translate(input logic [31:0] va, input logic [7:0] asid,
                                        input logic wr, output logic [31:0] pa,
                                        output logic [2:0] flags);
    int          hit;
    logic [19:0] pfn;
    logic        d;
    logic        v;
    pa    = '0;
    flags = '0;
    if (va >= `KSEG0_BASE && va < `KSEG1_BASE) begin
        pa = va - `KSEG0_BASE;
    end else if (va >= `KSEG1_BASE && va < `KSEG2_BASE) begin
        pa = va - `KSEG1_BASE;
    end else begin
        hit = find_entry(va[31:13], asid);
        if (hit < 0) begin
            flags[2] = 1'b1;
        end else begin
            if (va[12]) begin
                {pfn, d, v} = {shadow[hit].pfn1, shadow[hit].d1, shadow[hit].v1};
            end else begin
                {pfn, d, v} = {shadow[hit].pfn0, shadow[hit].d0, shadow[hit].v0};
            end
            pa       = {pfn, va[11:0]};
            flags[1] = !v;
            flags[0] = wr && !d;
        end
    end
endfunction

//--- sim/tb_mmu.sv
`include "mmu_cfg.svh"

module tb_mmu import mmu_pkg::*; ();

    // the sequence below needs roughly 600 cycles
    localparam int MAX_CYCLES = 2000;

    logic               clk;
    logic               reset;
    logic [31:0]        iaddr;
    logic [31:0]        daddr;
    logic               d_write;
    logic               op_start;
    tlb_op_e            op;
    logic               busy;
    logic               op_done;
    logic               cp0_wr_en;
    cp0_sel_e           cp0_sel;
    logic [31:0]        cp0_wr_data;
    logic [31:0]        cp0_rd_data;
    logic [31:0]        i_paddr;
    logic [31:0]        d_paddr;
    logic               i_refill;
    logic               i_invalid;
    logic               d_refill;
    logic               d_invalid;
    logic               d_modify;
    integer             seed;
    int                 cycles = 0;
    tlb_entry_t         shadow [`TLB_ENTRIES];
    logic [`ASID_W-1:0] cur_asid_m;

    mmu_top u_mmu_top (.*);

    `include "tb_mmu_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            report_fail("timeout: the test sequence did not complete");
        end
    end

    //////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////
    task automatic report_fail(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        a_value: assert (act === exp) else
            report_fail($sformatf("ERR %s: expected 0x%08h, actual 0x%08h", name, exp, act));
    endtask

    task automatic check_xlate(input string name, input logic [31:0] ia,
                               input logic [31:0] da, input logic wr);
        logic [31:0] exp_pa;
        logic [2:0]  exp_f;
        @(posedge clk);
        iaddr   <= ia;
        daddr   <= da;
        d_write <= wr;
        @(negedge clk);
        model_translate(ia, cur_asid_m, 1'b0, exp_pa, exp_f);
        check_eq({name, " i flags"}, {29'b0, exp_f}, {29'b0, i_refill, i_invalid, 1'b0});
        if (!exp_f[2]) begin
            check_eq({name, " i_paddr"}, exp_pa, i_paddr);
        end
        model_translate(da, cur_asid_m, wr, exp_pa, exp_f);
        check_eq({name, " d flags"}, {29'b0, exp_f}, {29'b0, d_refill, d_invalid, d_modify});
        if (!exp_f[2]) begin
            check_eq({name, " d_paddr"}, exp_pa, d_paddr);
        end
    endtask

    // even page fetch with odd page load, then the reverse as a store
    task automatic check_pages(input string name, input logic [18:0] vpn2);
        logic [11:0] off;
        off = 12'($random(seed));
        check_xlate(name, {vpn2, 1'b0, off}, {vpn2, 1'b1, ~off}, 1'b0);
        check_xlate(name, {vpn2, 1'b1, off}, {vpn2, 1'b0, off}, 1'b1);
    endtask

    task automatic check_entry(input string name, input int k);
        set_entryhi(shadow[k].vpn2, shadow[k].asid);
        check_pages(name, shadow[k].vpn2);
    endtask

    a_op_timing: assert property (@(posedge clk) disable iff (reset)
        (op_start && !busy) |=> (busy && !op_done) ##1 (busy && op_done))
        else report_fail("op_done did not come two cycles after op_start with busy high");

    a_kseg_i: assert property (@(posedge clk) disable iff (reset)
        (iaddr[31:30] == 2'b10) |-> (!i_refill && !i_invalid))
        else report_fail("fetch flag raised for an unmapped kseg address");

    a_kseg_d: assert property (@(posedge clk) disable iff (reset)
        (daddr[31:30] == 2'b10 && !op_done && !busy) |-> (!d_refill && !d_invalid && !d_modify))
        else report_fail("data flag raised for an unmapped kseg address");

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    initial begin
        logic [31:0] va;
        logic [18:0] vpn;
        logic [31:0] lo0;
        logic [31:0] lo1;
        logic [31:0] rd;
        seed        = 77;
        reset       = 1'b1;
        iaddr       = '0;
        daddr       = '0;
        d_write     = 1'b0;
        op_start    = 1'b0;
        op          = TLB_NOP;
        cp0_wr_en   = 1'b0;
        cp0_sel     = SEL_INDEX;
        cp0_wr_data = '0;
        cur_asid_m  = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // unmapped segments on an empty tlb
        for (int n = 0; n < 6; n++) begin
            va = `KSEG0_BASE + ($random(seed) & 32'h1FFF_FFFF);
            check_xlate("unmapped", va, va + 32'h2000_0000, 1'b0);
            check_xlate("unmapped", va + 32'h2000_0000, va, 1'b1);
        end

        // eight entries, entry 3 global
        for (int k = 0; k < 8; k++) begin
            vpn = {2'b01, 13'($random(seed)), 4'(k)};
            lo0 = make_lo(20'($random(seed)), 3'($random(seed)), 1'b1, 1'b1, k == 3);
            lo1 = make_lo(20'($random(seed)), 3'($random(seed)), 1'b1, 1'b1, k == 3);
            tlbwi_entry(k, vpn, 8'($random(seed)), lo0, lo1);
        end
        for (int k = 0; k < 8; k++) begin
            check_entry("tlbwi", k);
        end
        set_entryhi(shadow[3].vpn2, shadow[3].asid ^ 8'h5A);
        check_pages("global", shadow[3].vpn2);

        // refill, invalid even page, clean odd page
        vpn = {2'b01, 13'($random(seed)), 4'hE};
        check_xlate("refill", {vpn, 13'h0123}, {vpn, 13'h1456}, 1'b0);
        vpn = {2'b01, 13'($random(seed)), 4'h8};
        lo0 = make_lo(20'($random(seed)), 3'd2, 1'b1, 1'b0, 1'b0);
        lo1 = make_lo(20'($random(seed)), 3'd2, 1'b0, 1'b1, 1'b0);
        tlbwi_entry(8, vpn, 8'($random(seed)), lo0, lo1);
        check_xlate("invalid", {vpn, 13'h0040}, {vpn, 13'h1040}, 1'b0);
        check_xlate("modify", {vpn, 13'h1080}, {vpn, 13'h1080}, 1'b1);

        // probe hit and miss
        set_entryhi(shadow[5].vpn2, shadow[5].asid);
        issue_op(TLB_PROBE);
        cp0_read(SEL_INDEX, rd);
        check_eq("tlbp hit", 32'(find_entry(shadow[5].vpn2, shadow[5].asid)), rd);
        set_entryhi({2'b01, 13'($random(seed)), 4'hD}, cur_asid_m);
        issue_op(TLB_PROBE);
        cp0_read(SEL_INDEX, rd);
        check_eq("tlbp miss P", 32'd1, {31'd0, rd[31]});

        // read back every written entry
        for (int k = 0; k < 9; k++) begin
            cp0_write(SEL_INDEX, 32'(k));
            issue_op(TLB_READ);
            cp0_read(SEL_ENTRYHI, rd);
            check_eq("tlbr entryhi", {shadow[k].vpn2, 5'b0, shadow[k].asid}, rd);
            cp0_read(SEL_ENTRYLO0, rd);
            check_eq("tlbr entrylo0", make_lo(shadow[k].pfn0, shadow[k].c0, shadow[k].d0,
                                              shadow[k].v0, shadow[k].g), rd);
            cp0_read(SEL_ENTRYLO1, rd);
            check_eq("tlbr entrylo1", make_lo(shadow[k].pfn1, shadow[k].c1, shadow[k].d1,
                                              shadow[k].v1, shadow[k].g), rd);
        end
        cur_asid_m = shadow[8].asid;

        //////////////////////////////////////////////////
        // wired boundary and random writes
        //////////////////////////////////////////////////
        cp0_write(SEL_WIRED, 32'd6);
        cp0_read(SEL_WIRED, rd);
        check_eq("wired", 32'd6, rd);
        repeat (20) begin
            cp0_read(SEL_RANDOM, rd);
            a_random_range: assert (rd >= 6 && rd <= 15) else
                report_fail($sformatf("ERR wired random: expected 6 to 15, actual %0d", rd));
        end
        for (int n = 0; n < 4; n++) begin
            vpn = {2'b01, 13'($random(seed)), 4'(9 + n)};
            lo0 = make_lo(20'($random(seed)), 3'd3, 1'b1, 1'b1, 1'b0);
            lo1 = make_lo(20'($random(seed)), 3'd3, 1'b1, 1'b1, 1'b0);
            set_entryhi(vpn, 8'($random(seed)));
            cp0_write(SEL_ENTRYLO0, lo0);
            cp0_write(SEL_ENTRYLO1, lo1);
            issue_op(TLB_WRITE_RND);
            issue_op(TLB_PROBE);
            cp0_read(SEL_INDEX, rd);
            a_rnd_slot: assert (!rd[31] && rd[3:0] >= 6) else
                report_fail($sformatf("ERR tlbwr index: expected 6 to 15, actual 0x%08h",
                                      rd));
            shadow_store(rd[3:0], vpn, cur_asid_m, lo0, lo1);
            check_pages("tlbwr", vpn);
        end
        for (int k = 0; k < 6; k++) begin
            check_entry("wired", k);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- sources.f
+incdir+src
+incdir+sim
src/mmu_pkg.sv
src/tlb_if.sv
src/tlb.sv
src/tlb_random.sv
src/tlb_ctrl.sv
src/mmu_translate.sv
src/mmu_top.sv
sim/tb_mmu.sv
